//--- filelist.f
hw/tgen_pkg.sv
hw/tgen_wr.sv
hw/axi_wr_mem.sv
hw/tgen_top.sv
tb/tgen_checker.sv
tb/tgen_tb.sv

//--- hw/axi_wr_mem.sv
`default_nettype none

module axi_wr_mem
  import tgen_pkg::*;
#(
  parameter int mem_words = 4096  // power of two, addresses wrap.
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  aw_chan_t                     aw,
  input  logic                         aw_valid,
  output logic                         aw_ready,
  input  w_chan_t                      w,
  input  logic                         w_valid,
  output logic                         w_ready,
  output b_chan_t                      b,
  output logic                         b_valid,
  input  logic                         b_ready,
  input  logic [$clog2(mem_words)-1:0] rd_addr,
  output logic [data_w-1:0]            rd_data
);

  localparam int idx_w     = $clog2(mem_words);
  localparam int lane_bits = $clog2(strb_w);

  logic [data_w-1:0] mem [mem_words];

  logic [addr_w-1:0] addr_q;  // byte address of the next beat.
  logic [2:0]        size_q;
  logic [1:0]        burst_q;
  logic [id_w-1:0]   id_q;
  logic [idx_w-1:0]  w_idx;
  logic              aw_fire;
  logic              w_fire;
  logic              b_fire;

  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;
  assign b_fire  = b_valid && b_ready;

  assign w_idx = addr_q[idx_w+lane_bits-1:lane_bits];  // modulo depth.

  // ####################################################################
  // handshake control
  // ####################################################################
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_ready <= 1'b1;
      w_ready  <= 1'b0;
      b_valid  <= 1'b0;
    end else begin
      if (aw_fire) begin
        aw_ready <= 1'b0;
        w_ready  <= 1'b1;
      end
      if (w_fire && w.last) begin
        w_ready <= 1'b0;
        b_valid <= 1'b1;
      end
      if (b_fire) begin
        b_valid  <= 1'b0;
        aw_ready <= 1'b1;  // ready for the next burst.
      end
    end
  end

  // burst state taken from the address channel.
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      addr_q  <= aw.addr;
      size_q  <= aw.size;
      burst_q <= aw.burst;
      id_q    <= aw.id;
    end else if (w_fire && (burst_q == burst_incr)) begin
      addr_q <= addr_q + (addr_w'(1) << size_q);
    end
  end

  assign b = '{id: id_q, resp: resp_okay};

  // ####################################################################
  // storage
  // ####################################################################
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < mem_words; i++) begin
        mem[i] <= '0;
      end
    end else if (w_fire) begin
      for (int j = 0; j < strb_w; j++) begin
        if (w.strb[j]) begin
          mem[w_idx][j*8 +: 8] <= w.data[j*8 +: 8];
        end
      end
    end
  end

  // read-back port, one cycle.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- hw/tgen_pkg.sv
`default_nettype none

package tgen_pkg;

  // ####################################################################
  // bus widths
  // ####################################################################
  localparam int addr_w = 16;  // byte address.
  localparam int data_w = 16;  // two byte lanes.
  localparam int id_w   = 4;
  localparam int strb_w = data_w / 8;

  localparam logic [1:0] burst_incr = 2'b01;
  localparam logic [1:0] resp_okay  = 2'b00;

  // one generator run.
  typedef struct packed {
    logic [addr_w-1:0] base_addr;
    logic [id_w-1:0]   id;
    logic [7:0]        beats;   // beats per burst.
    logic [addr_w-1:0] stride;  // bytes between burst starts.
    logic [2:0]        size;    // awsize code, 0 or 1.
    logic [15:0]       num;     // number of bursts.
  } burst_cfg_t;

  // ####################################################################
  // axi write channels
  // ####################################################################
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [id_w-1:0]   id;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } aw_chan_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } w_chan_t;

  typedef struct packed {
    logic [id_w-1:0] id;
    logic [1:0]      resp;
  } b_chan_t;

endpackage

`default_nettype wire

//--- hw/tgen_top.sv
`default_nettype none

module tgen_top
  import tgen_pkg::*;
#(
  parameter int mem_words = 4096
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  burst_cfg_t                   cfg,
  output logic                         busy,
  input  logic [$clog2(mem_words)-1:0] rd_addr,
  output logic [data_w-1:0]            rd_data
);

  // write channels between generator and memory.
  aw_chan_t aw;
  logic     aw_valid;
  logic     aw_ready;
  w_chan_t  w;
  logic     w_valid;
  logic     w_ready;
  b_chan_t  b;
  logic     b_valid;
  logic     b_ready;

  tgen_wr u_tgen_wr (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .cfg      (cfg),
    .busy     (busy),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready)
  );

  axi_wr_mem #(
    .mem_words (mem_words)
  ) u_axi_wr_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

`default_nettype wire

//--- hw/tgen_wr.sv
`default_nettype none

module tgen_wr
  import tgen_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  burst_cfg_t cfg,
  output logic       busy,
  output aw_chan_t   aw,
  output logic       aw_valid,
  input  logic       aw_ready,
  output w_chan_t    w,
  output logic       w_valid,
  input  logic       w_ready,
  input  b_chan_t    b,
  input  logic       b_valid,
  output logic       b_ready
);

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data,
    st_resp
  } state_t;

  state_t            state;
  burst_cfg_t        cfg_q;
  logic [15:0]       bursts_left;
  logic [7:0]        beat_idx;
  logic [addr_w-1:0] burst_addr;  // start of the current burst.
  logic [addr_w-1:0] beat_addr;   // address of the current beat.
  logic [addr_w-1:0] beat_step;
  logic              start_ok;
  logic              aw_fire;
  logic              w_fire;
  logic              b_fire;

  assign start_ok = (state == st_idle) && start && (cfg.num != 16'd0);
  assign aw_fire  = aw_valid && aw_ready;
  assign w_fire   = w_valid && w_ready;
  // only one burst is in flight, so the response must carry our id.
  assign b_fire   = (state == st_resp) && b_valid && b_ready && (b.id == cfg_q.id);

  assign busy     = (state != st_idle);
  assign aw_valid = (state == st_addr);
  assign w_valid  = (state == st_data);
  assign b_ready  = 1'b1;  // responses are always taken.

  assign beat_step = addr_w'(1) << cfg_q.size;

  // ####################################################################
  // control
  // ####################################################################
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= st_idle;
      bursts_left <= '0;
      beat_idx    <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start_ok) begin
            state       <= st_addr;
            bursts_left <= cfg.num;
          end
        end
        st_addr: begin
          if (aw_fire) begin
            state    <= st_data;
            beat_idx <= '0;
          end
        end
        st_data: begin
          if (w_fire) begin
            if (w.last) begin
              state <= st_resp;
            end else begin
              beat_idx <= beat_idx + 8'd1;
            end
          end
        end
        st_resp: begin
          if (b_fire) begin
            bursts_left <= bursts_left - 16'd1;
            state       <= (bursts_left == 16'd1) ? st_idle : st_addr;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // run config and address tracking.
  always_ff @(posedge clk) begin
    if (start_ok) begin
      cfg_q      <= cfg;
      burst_addr <= cfg.base_addr;
    end else if (b_fire) begin
      burst_addr <= burst_addr + cfg_q.stride;  // next burst start.
    end
    if (aw_fire) begin
      beat_addr <= burst_addr;
    end else if (w_fire) begin
      beat_addr <= beat_addr + beat_step;
    end
  end

  // ####################################################################
  // channel payloads
  // ####################################################################
  always_comb begin
    aw.addr  = burst_addr;
    aw.id    = cfg_q.id;
    aw.len   = cfg_q.beats - 8'd1;
    aw.size  = cfg_q.size;
    aw.burst = burst_incr;
  end

  always_comb begin
    w.last = (beat_idx == aw.len);
    if (cfg_q.size == 3'd0) begin
      // byte beat: low address byte on every lane, one lane enabled.
      w.data = {strb_w{beat_addr[7:0]}};
      w.strb = strb_w'(1) << beat_addr[0];
    end else begin
      w.data = data_w'(beat_addr);
      w.strb = '1;
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the write-traffic testbench with Verilator, run it and judge the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tgen_tb \
  --Mdir obj_dir -o tgen_sim \
  -f filelist.f

./obj_dir/tgen_sim | tee sim.log

if grep -q "^all tests passed$" sim.log; then
  echo "simulation PASS"
  exit 0
else
  echo "simulation FAIL, see sim.log"
  exit 1
fi

//--- tb/tgen_checker.sv
`default_nettype none

module tgen_checker
  import tgen_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     busy,
  input aw_chan_t aw,
  input logic     aw_valid,
  input logic     aw_ready,
  input w_chan_t  w,
  input logic     w_valid,
  input logic     w_ready,
  input b_chan_t  b,
  input logic     b_valid,
  input logic     b_ready
);

  logic [7:0] len_q;  // len of the burst in flight.
  logic [7:0] beat_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      len_q    <= '0;
      beat_cnt <= '0;
    end else if (aw_valid && aw_ready) begin
      len_q    <= aw.len;
      beat_cnt <= '0;
    end else if (w_valid && w_ready) begin
      beat_cnt <= beat_cnt + 8'd1;
    end
  end

  // ####################################################################
  // handshake stability
  // ####################################################################
  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else $error("aw valid or payload changed before the transfer");

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid && !w_ready |=> w_valid && $stable(w))
    else $error("w valid or payload changed before the transfer");

  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else $error("b valid or payload changed before the transfer");

  // ####################################################################
  // burst framing
  // ####################################################################
  last_frame: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid && w_ready |-> (w.last == (beat_cnt == len_q)))
    else $error("wlast does not match the final beat of the burst");

  idle_no_aw: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> !aw_valid)
    else $error("aw_valid raised while the generator is idle");

endmodule

bind tgen_top tgen_checker u_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .busy     (busy),
  .aw       (aw),
  .aw_valid (aw_valid),
  .aw_ready (aw_ready),
  .w        (w),
  .w_valid  (w_valid),
  .w_ready  (w_ready),
  .b        (b),
  .b_valid  (b_valid),
  .b_ready  (b_ready)
);

`default_nettype wire

//--- tb/tgen_tb.sv
`default_nettype none

module tgen_tb
  import tgen_pkg::*;
();

  localparam int mem_words = 512;
  localparam int idx_w     = $clog2(mem_words);
  localparam int n_tests   = 13;  // three directed runs, ten random.

  logic              clk = 1'b0;
  logic              rst_n;
  logic              start;
  burst_cfg_t        cfg;
  logic              busy;
  logic [idx_w-1:0]  rd_addr;
  logic [data_w-1:0] rd_data;

  logic [data_w-1:0] ref_mem [mem_words];  // expected memory image.
  burst_cfg_t        cfg_list [n_tests];
  logic              check_pending = 1'b0;
  integer            seed;
  int                errors      = 0;
  int                cycles      = 0;
  int                cycle_limit = 1000;

  always #2 clk = ~clk;

  tgen_top #(
    .mem_words (mem_words)
  ) DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .cfg     (cfg),
    .busy    (busy),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // ####################################################################
  // reference model and checks
  // ####################################################################
  task automatic check_value(input string name, input logic [data_w-1:0] got,
                             input logic [data_w-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // beat k of burst n lands at base + n*stride + k*2^size.
  function automatic void model_run(input burst_cfg_t c);
    logic [addr_w-1:0] a;
    logic [addr_w-1:0] step;
    int                idx;
    step = (c.size == 3'd0) ? 16'd1 : 16'd2;
    for (int n = 0; n < int'(c.num); n++) begin
      for (int k = 0; k < int'(c.beats); k++) begin
        a   = c.base_addr + addr_w'(n) * c.stride + addr_w'(k) * step;
        idx = int'(a[addr_w-1:1]) % mem_words;
        if (c.size != 3'd0) begin
          ref_mem[idx] = a;
        end else if (a[0]) begin
          ref_mem[idx][15:8] = a[7:0];  // odd byte, upper lane.
        end else begin
          ref_mem[idx][7:0] = a[7:0];
        end
      end
    end
  endfunction

  function automatic burst_cfg_t make_cfg(input logic [addr_w-1:0] base,
      input logic [id_w-1:0] id, input logic [7:0] beats,
      input logic [addr_w-1:0] stride, input logic [2:0] size, input logic [15:0] num);
    burst_cfg_t c;
    c.base_addr = base;
    c.id        = id;
    c.beats     = beats;
    c.stride    = stride;
    c.size      = size;
    c.num       = num;
    return c;
  endfunction

  task automatic build_tests();
    logic [31:0] r;
    burst_cfg_t  c;
    int          work;
    cfg_list[0] = make_cfg(16'h1000, 4'd3, 8'd4, 16'h0000, 3'd1, 16'd1);
    cfg_list[1] = make_cfg(16'h0200, 4'd5, 8'd2, 16'h0008, 3'd1, 16'd3);
    // byte lanes over words written by the first run.
    cfg_list[2] = make_cfg(16'h1003, 4'd6, 8'd3, 16'h0005, 3'd0, 16'd2);
    for (int t = 3; t < n_tests; t++) begin
      r           = $random(seed);
      c.size      = {2'b00, r[0]};
      c.beats     = 8'(r[3:1]) + 8'd1;
      c.num       = 16'(r[5:4]) + 16'd1;
      c.id        = r[9:6];
      c.stride    = {8'h00, r[17:10]};
      r           = $random(seed);
      c.base_addr = r[addr_w-1:0];
      if (c.size == 3'd1) begin
        c.base_addr[0] = 1'b0;  // word beats stay lane aligned.
        c.stride[0]    = 1'b0;
      end
      cfg_list[t] = c;
    end
    work = (n_tests + 1) * (mem_words + 2);  // one image sweep per run plus reset.
    for (int t = 0; t < n_tests; t++) begin
      work += int'(cfg_list[t].num) * (int'(cfg_list[t].beats) + 4);
    end
    cycle_limit = 2 * work + 64;
  endtask

  // sweep the read-back port over the whole image.
  initial begin
    forever begin
      wait (check_pending);
      for (int i = 0; i < mem_words; i++) begin
        rd_addr = idx_w'(i);
        @(negedge clk);
        check_value($sformatf("rd_data[%0d]", i), rd_data, ref_mem[i]);
      end
      check_pending = 1'b0;
    end
  end

  task automatic compare_image();
    check_pending = 1'b1;
    wait (!check_pending);
  endtask

  task automatic run_cfg(input burst_cfg_t c);
    check_value("busy", data_w'(busy), '0);  // previous run must be over.
    cfg   = c;
    start = 1'b1;
    @(negedge clk);
    check_value("busy", data_w'(busy), data_w'(1));
    start = 1'b0;
    while (busy) begin
      @(negedge clk);
    end
    model_run(c);
    compare_image();
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $fatal(1, "timeout");
    end
  end

  // ####################################################################
  // test sequence
  // ####################################################################
  initial begin
    rst_n   = 1'b0;
    start   = 1'b0;
    cfg     = '0;
    rd_addr = '0;
    seed    = 32'h084c_37aa;
    for (int i = 0; i < mem_words; i++) begin
      ref_mem[i] = '0;
    end
    build_tests();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("busy", data_w'(busy), '0);
    compare_image();  // memory cleared by reset.
    for (int t = 0; t < n_tests; t++) begin
      run_cfg(cfg_list[t]);
    end
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
